/* Bender.yml */
package:
  name: clkBoard

sources:
  - clkPkg.sv
  - clkDiagPort.sv
  - clkCtlRegs.sv
  - burstCounter.sv
  - eboxClkGate.sv
  - parityErrLatch.sv
  - clkBoard.sv
  - target: test
    files:
      - clkBoard_checker.sv
      - clkGen.sv
      - clkBoard_tb.sv

/* burstCounter.sv */
// 8-bit burst counter with nibble loads and count-down
`default_nettype none

module burstCounter (
  input  logic                           CLK,
  input  logic                           rst,
  input  logic                           ldBurstLo,
  input  logic                           ldBurstHi,
  input  logic [clkPkg::NibbleWidth-1:0] loadNibble,
  input  logic                           burstStep,
  output logic [clkPkg::DataWidth-1:0]   burstCount,
  output logic                           burstZero
);

  assign burstZero = (burstCount == '0);

  always_ff @(posedge CLK) begin
    if (rst) begin
      burstCount <= '0;
    end else if (ldBurstLo) begin
      burstCount[clkPkg::NibbleWidth-1:0] <= loadNibble;  // High nibble kept
    end else if (ldBurstHi) begin
      burstCount[2*clkPkg::NibbleWidth-1:clkPkg::NibbleWidth] <= loadNibble;
    end else if (burstStep && !burstZero) begin
      burstCount <= burstCount - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* clkBoard.sv */
// Clock board top: diagnostic port, control registers, burst counter,
// clock gating and parity error latch
`default_nettype none

module clkBoard (
  input  logic                         CLK,
  input  logic                         rst,
  input  logic                         wbCyc,
  input  logic                         wbStb,
  input  logic                         wbWe,
  input  logic [clkPkg::AdrWidth-1:0]  wbAdr,
  input  logic [clkPkg::DataWidth-1:0] wbDatW,
  output logic [clkPkg::DataWidth-1:0] wbDatR,
  output logic                         wbAck,
  input  logic                         fmParityOk,
  input  logic                         cramParityOk,
  input  logic                         dramParityOk,
  output logic                         eboxClkEn,
  output logic                         crmClkEn,
  output logic                         edpClkEn,
  output logic                         ctlClkEn,
  output logic                         clkReset,
  output logic                         errorStop
);

  logic startFn, stopFn, stepFn, burstFn, clrResetFn, setResetFn;
  logic ldBurstLo, ldBurstHi, ldClkDis, ldParCheck, ldErrStop;
  clkPkg::ctlWord_u ctlWord;
  logic [clkPkg::NibbleWidth-1:0] loadNibble;
  logic [clkPkg::DataWidth-1:0] burstCount;
  logic burstZero, burstStep;
  logic runMode, burstMode;
  logic crmDis, edpDis, ctlDis;
  logic fmCheck, cramCheck, dramCheck, errStopEn;
  logic [clkPkg::ErrWidth-1:0] errFlags;

  clkDiagPort uDiagPort (
    .CLK(CLK), .rst(rst),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
    .burstCount(burstCount), .runMode(runMode), .burstMode(burstMode),
    .clkReset(clkReset), .errorStop(errorStop),
    .clkDisWord({crmDis, edpDis, ctlDis}),
    .parCheckWord({fmCheck, cramCheck, dramCheck}),
    .errStopEn(errStopEn), .errFlags(errFlags),
    .parityIn({fmParityOk, cramParityOk, dramParityOk}),
    .wbAck(wbAck), .wbDatR(wbDatR),
    .startFn(startFn), .stopFn(stopFn), .stepFn(stepFn), .burstFn(burstFn),
    .clrResetFn(clrResetFn), .setResetFn(setResetFn),
    .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi), .ldClkDis(ldClkDis),
    .ldParCheck(ldParCheck), .ldErrStop(ldErrStop),
    .ctlWord(ctlWord), .loadNibble(loadNibble)
  );

  clkCtlRegs uCtlRegs (
    .CLK(CLK), .rst(rst),
    .ldClkDis(ldClkDis), .ldParCheck(ldParCheck), .ldErrStop(ldErrStop),
    .ctlWord(ctlWord),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .fmCheck(fmCheck), .cramCheck(cramCheck), .dramCheck(dramCheck),
    .errStopEn(errStopEn)
  );

  burstCounter uBurstCounter (
    .CLK(CLK), .rst(rst),
    .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi), .loadNibble(loadNibble),
    .burstStep(burstStep), .burstCount(burstCount), .burstZero(burstZero)
  );

  eboxClkGate uClkGate (
    .CLK(CLK), .rst(rst),
    .startFn(startFn), .stopFn(stopFn), .stepFn(stepFn), .burstFn(burstFn),
    .clrResetFn(clrResetFn), .setResetFn(setResetFn),
    .burstZero(burstZero), .errorStop(errorStop),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .runMode(runMode), .burstMode(burstMode), .clkReset(clkReset),
    .eboxClkEn(eboxClkEn), .crmClkEn(crmClkEn), .edpClkEn(edpClkEn),
    .ctlClkEn(ctlClkEn), .burstStep(burstStep)
  );

  parityErrLatch uParErr (
    .CLK(CLK), .rst(rst),
    .clrResetFn(clrResetFn), .eboxClkEn(eboxClkEn),
    .fmParityOk(fmParityOk), .cramParityOk(cramParityOk), .dramParityOk(dramParityOk),
    .fmCheck(fmCheck), .cramCheck(cramCheck), .dramCheck(dramCheck),
    .errStopEn(errStopEn), .errFlags(errFlags), .errorStop(errorStop)
  );

endmodule

`default_nettype wire

/* clkBoard_checker.sv */
// Concurrent assertions on the Wishbone handshake and the clock enables
`default_nettype none

module clkBoard_checker (
  input logic CLK,
  input logic rst,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck,
  input logic eboxClkEn,
  input logic crmClkEn,
  input logic edpClkEn,
  input logic ctlClkEn,
  input logic errorStop
);

  int assertFails = 0;  // Polled by the testbench

  ackOneCycle: assert property (@(posedge CLK) disable iff (rst) wbAck |=> !wbAck)
    else begin
      assertFails++;
      $error("wbAck held for more than one cycle");
    end

  ackAfterReq: assert property (@(posedge CLK) disable iff (rst)
    wbAck |-> $past(wbCyc && wbStb))
    else begin
      assertFails++;
      $error("wbAck without a preceding cyc and stb");
    end

  subEnables: assert property (@(posedge CLK) disable iff (rst)
    (crmClkEn || edpClkEn || ctlClkEn) |-> eboxClkEn)
    else begin
      assertFails++;
      $error("CRM, EDP or CTL enable high without the EBOX enable");
    end

  stopHolds: assert property (@(posedge CLK) disable iff (rst) errorStop |-> !eboxClkEn)
    else begin
      assertFails++;
      $error("EBOX enable high during error stop");
    end

endmodule

`default_nettype wire

/* clkBoard_tb.sv */
// Testbench for the clock board: bus tasks, status model, reference
// function, compare process and timeout
`default_nettype none

module clkBoard_tb;

  localparam int TimeoutCycles = 4000;  // Tests need about 900 cycles

  logic CLK;
  logic rst;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  logic [3:0] wbAdr;
  logic [7:0] wbDatW;
  logic [7:0] wbDatR;
  logic wbAck;
  logic [2:0] parOk;  // fm, cram, dram
  logic eboxClkEn, crmClkEn, edpClkEn, ctlClkEn, clkReset, errorStop;

  // Status model
  logic [7:0] mBurst;
  logic mRun, mBurstMode, mClkReset, mErrStopEn;
  logic [2:0] mClkDis, mParCheck, mErrFlags;

  int cycles = 0;
  int ackCycle = 0;
  int enCount = 0;
  string nameQ[$];
  logic [7:0] gotQ[$];
  logic [7:0] expQ[$];

  clkGen uClkGen (.CLK(CLK), .rst(rst));

  clkBoard u_dut (
    .CLK(CLK), .rst(rst),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
    .wbDatR(wbDatR), .wbAck(wbAck),
    .fmParityOk(parOk[2]), .cramParityOk(parOk[1]), .dramParityOk(parOk[0]),
    .eboxClkEn(eboxClkEn), .crmClkEn(crmClkEn), .edpClkEn(edpClkEn),
    .ctlClkEn(ctlClkEn), .clkReset(clkReset), .errorStop(errorStop)
  );

  bind clkBoard clkBoard_checker uChecker (
    .CLK(CLK), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
    .eboxClkEn(eboxClkEn), .crmClkEn(crmClkEn), .edpClkEn(edpClkEn),
    .ctlClkEn(ctlClkEn), .errorStop(errorStop)
  );

  function automatic logic [7:0] refReadWord(input logic [2:0] sel);
    logic [7:0] w;
    logic stopNow;
    w = 8'h00;
    stopNow = (|mErrFlags) & mErrStopEn;
    case (sel)
      clkPkg::RdBurst:    w = mBurst;
      clkPkg::RdMode:     w = {4'h0, mRun, mBurstMode, mClkReset, stopNow};
      clkPkg::RdClkDis:   w = {5'h00, mClkDis};
      clkPkg::RdParCheck: w = {5'h00, mParCheck};
      clkPkg::RdErrStop:  w = {7'h00, mErrStopEn};
      clkPkg::RdErrFlags: w = {5'h00, mErrFlags};
      clkPkg::RdParityIn: w = {5'h00, parOk};
      default:            w = 8'h00;
    endcase
    return w;
  endfunction

  task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // One classic cycle; returns at the edge that ends the ack cycle
  task automatic transfer(input logic we, input logic [3:0] adr, input logic [7:0] dat,
                          output logic [7:0] rdData);
    @(posedge CLK);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= we;
    wbAdr  <= adr;
    wbDatW <= dat;
    do begin
      @(posedge CLK);
    end while (!wbAck);
    rdData   = wbDatR;
    ackCycle = cycles;
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  task automatic readWord(input logic [2:0] sel);
    logic [7:0] d;
    transfer(1'b0, {1'b0, sel}, 8'h00, d);
    nameQ.push_back($sformatf("wbDatR sel %0d", sel));
    gotQ.push_back(d);
    expQ.push_back(refReadWord(sel));
  endtask

  task automatic readAll();
    for (int s = 0; s < 8; s++)
      readWord(s[2:0]);
  endtask

  task automatic loadReg(input logic [2:0] fn, input logic [7:0] dat);
    logic [7:0] d;
    transfer(1'b1, {1'b1, fn}, dat, d);
    case (fn)
      clkPkg::LdBurstLo:  mBurst[3:0] = dat[3:0];
      clkPkg::LdBurstHi:  mBurst[7:4] = dat[3:0];
      clkPkg::LdClkDis:   mClkDis = dat[2:0];
      clkPkg::LdParCheck: mParCheck = dat[2:0];
      clkPkg::LdErrStop:  mErrStopEn = dat[0];
      default: ;  // Unused load slots
    endcase
  endtask

  task automatic issueFunc(input logic [2:0] fn);
    logic [7:0] d;
    transfer(1'b1, {1'b0, fn}, 8'h00, d);
    case (fn)
      clkPkg::FuncStart:      mRun = 1'b1;
      clkPkg::FuncStop:       mRun = 1'b0;
      clkPkg::FuncSingleStep: mRun = 1'b0;
      clkPkg::FuncSetReset:   mClkReset = 1'b0;
      clkPkg::FuncClrReset: begin
        mClkReset = 1'b1;
        mErrFlags = 3'b000;
      end
      default: ;
    endcase
  endtask

  // Parity-ok bits in mask held low for two cycles
  task automatic dropParity(input logic [2:0] mask);
    @(posedge CLK);
    parOk <= ~mask;
    repeat (2) @(posedge CLK);
    parOk <= 3'b111;
  endtask

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: test did not finish within %0d cycles", TimeoutCycles);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  // Compare process, away from the active edge
  always @(negedge CLK) begin
    if (!rst) begin
      expectEq("crmClkEn", crmClkEn, eboxClkEn & ~mClkDis[2]);
      expectEq("edpClkEn", edpClkEn, eboxClkEn & ~mClkDis[1]);
      expectEq("ctlClkEn", ctlClkEn, eboxClkEn & ~mClkDis[0]);
      if (!wbAck)
        expectEq("wbDatR idle", wbDatR, 8'h00);
      if (eboxClkEn)
        enCount++;
    end
    while (gotQ.size() > 0)
      expectEq(nameQ.pop_front(), gotQ.pop_front(), expQ.pop_front());
    if (u_dut.uChecker.assertFails != 0) begin
      $display("A bound assertion on the clock board failed");
      $display("*** FAILED ***");
      $fatal(1, "Assertion failure");
    end
  end

  initial begin
    logic [7:0] v;
    int n;
    int k;
    int startAck;
    void'($urandom(87));
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = 4'h0;
    wbDatW = 8'h00;
    parOk = 3'b111;
    mBurst = 8'h00;
    mRun = 1'b0;
    mBurstMode = 1'b0;
    mClkReset = 1'b1;
    mErrStopEn = 1'b0;
    mClkDis = 3'b000;
    mParCheck = 3'b000;
    mErrFlags = 3'b000;
    while (rst !== 1'b0)
      @(posedge CLK);

    readAll();  // Reset values, clkReset high
    for (int r = 0; r < 6; r++) begin
      for (int f = 0; f < 8; f++) begin
        v = $urandom;
        loadReg(f[2:0], v);
      end
      issueFunc(3'd0);
      issueFunc(3'd4);
      readAll();
    end
    loadReg(clkPkg::LdErrStop, 8'h00);

    // Burst counts, the first one empty and the last one full length
    for (int r = 0; r < 4; r++) begin
      n = (r == 0) ? 0 : (r == 3) ? 20 : $urandom_range(20, 1);
      loadReg(clkPkg::LdBurstLo, n[7:0] & 8'h0f);
      loadReg(clkPkg::LdBurstHi, n[7:0] >> 4);
      readWord(clkPkg::RdBurst);
      enCount = 0;
      issueFunc(clkPkg::FuncBurst);
      if (n >= 4) begin
        mBurstMode = 1'b1;  // Read ack falls in the third burst cycle
        readWord(clkPkg::RdMode);
        mBurstMode = 1'b0;
      end
      repeat (n + 4) @(posedge CLK);
      expectEq("burst eboxClkEn cycles", enCount, n);
      mBurst = 8'h00;
      readWord(clkPkg::RdBurst);
      readWord(clkPkg::RdMode);
    end

    enCount = 0;
    issueFunc(clkPkg::FuncSingleStep);
    repeat (4) @(posedge CLK);
    expectEq("step eboxClkEn cycles", enCount, 1);

    for (int r = 0; r < 3; r++) begin
      v = $urandom;
      loadReg(clkPkg::LdClkDis, v);
      issueFunc(clkPkg::FuncStart);
      startAck = ackCycle;
      enCount = 0;
      k = $urandom_range(30, 5);
      repeat (k) @(posedge CLK);
      readWord(clkPkg::RdMode);
      issueFunc(clkPkg::FuncStop);
      repeat (3) @(posedge CLK);
      expectEq("run eboxClkEn cycles", enCount, ackCycle - startAck);
      readWord(clkPkg::RdMode);
    end

    // FM and CRAM checked, DRAM not, no error stop
    loadReg(clkPkg::LdParCheck, 8'h06);
    issueFunc(clkPkg::FuncStart);
    dropParity(3'b100);
    mErrFlags[2] = 1'b1;
    dropParity(3'b001);
    issueFunc(clkPkg::FuncStop);
    readWord(clkPkg::RdErrFlags);
    @(posedge CLK);
    parOk <= 3'b010;
    readWord(clkPkg::RdParityIn);
    @(posedge CLK);
    parOk <= 3'b111;
    issueFunc(clkPkg::FuncClrReset);
    readWord(clkPkg::RdErrFlags);
    issueFunc(clkPkg::FuncSetReset);
    readWord(clkPkg::RdMode);

    // Error stop on a CRAM failure
    loadReg(clkPkg::LdErrStop, 8'h01);
    issueFunc(clkPkg::FuncStart);
    dropParity(3'b010);
    mErrFlags[1] = 1'b1;
    mRun = 1'b0;
    repeat (2) @(posedge CLK);
    enCount = 0;
    repeat (6) @(posedge CLK);
    expectEq("eboxClkEn cycles in error stop", enCount, 0);
    expectEq("errorStop", errorStop, 1);
    expectEq("clkReset", clkReset, 0);
    readWord(clkPkg::RdMode);
    readWord(clkPkg::RdErrFlags);
    issueFunc(clkPkg::FuncClrReset);
    readWord(clkPkg::RdMode);
    readWord(clkPkg::RdErrFlags);
    @(posedge CLK);
    expectEq("errorStop", errorStop, 0);
    expectEq("clkReset", clkReset, 1);

    repeat (3) @(posedge CLK);
    if (gotQ.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Read words were left uncompared at the end of the run");
      $display("*** FAILED ***");
      $fatal(1, "Compare queue not drained");
    end
  end

endmodule

`default_nettype wire

/* clkCtlRegs.sv */
// Clock disable, parity check and error stop registers
`default_nettype none

module clkCtlRegs (
  input  logic             CLK,
  input  logic             rst,
  input  logic             ldClkDis,
  input  logic             ldParCheck,
  input  logic             ldErrStop,
  input  clkPkg::ctlWord_u ctlWord,
  output logic             crmDis,
  output logic             edpDis,
  output logic             ctlDis,
  output logic             fmCheck,
  output logic             cramCheck,
  output logic             dramCheck,
  output logic             errStopEn
);

  always_ff @(posedge CLK) begin
    if (rst) begin
      crmDis    <= 1'b0;
      edpDis    <= 1'b0;
      ctlDis    <= 1'b0;
      fmCheck   <= 1'b0;
      cramCheck <= 1'b0;
      dramCheck <= 1'b0;
      errStopEn <= 1'b0;
    end else begin
      if (ldClkDis) begin  // 045
        crmDis <= ctlWord.clkDis.crmDis;
        edpDis <= ctlWord.clkDis.edpDis;
        ctlDis <= ctlWord.clkDis.ctlDis;
      end
      if (ldParCheck) begin  // 046
        fmCheck   <= ctlWord.parCheck.fmCheck;
        cramCheck <= ctlWord.parCheck.cramCheck;
        dramCheck <= ctlWord.parCheck.dramCheck;
      end
      // 047, only error stop survives
      if (ldErrStop)
        errStopEn <= ctlWord.errStop.errStopEn;
    end
  end

endmodule

`default_nettype wire

/* clkDiagPort.sv */
// Wishbone classic slave for the diagnostic port
// Function decode, load strobes and status read-back
`default_nettype none

module clkDiagPort (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic                               wbCyc,
  input  logic                               wbStb,
  input  logic                               wbWe,
  input  logic [clkPkg::AdrWidth-1:0]        wbAdr,
  input  logic [clkPkg::DataWidth-1:0]       wbDatW,
  input  logic [clkPkg::DataWidth-1:0]       burstCount,
  input  logic                               runMode,
  input  logic                               burstMode,
  input  logic                               clkReset,
  input  logic                               errorStop,
  input  logic [2:0]                         clkDisWord,
  input  logic [2:0]                         parCheckWord,
  input  logic                               errStopEn,
  input  logic [clkPkg::ErrWidth-1:0]        errFlags,
  input  logic [clkPkg::ErrWidth-1:0]        parityIn,
  output logic                               wbAck,
  output logic [clkPkg::DataWidth-1:0]       wbDatR,
  output logic                               startFn,
  output logic                               stopFn,
  output logic                               stepFn,
  output logic                               burstFn,
  output logic                               clrResetFn,
  output logic                               setResetFn,
  output logic                               ldBurstLo,
  output logic                               ldBurstHi,
  output logic                               ldClkDis,
  output logic                               ldParCheck,
  output logic                               ldErrStop,
  output clkPkg::ctlWord_u                   ctlWord,
  output logic [clkPkg::NibbleWidth-1:0]     loadNibble
);

  logic ackDone;  // Ack given, waiting for stb to drop
  logic ctlWr;
  logic ldWr;
  logic [clkPkg::FuncWidth-1:0] fnSel;
  logic [clkPkg::DataWidth-1:0] rdWord;

  always_ff @(posedge CLK) begin
    if (rst) begin
      wbAck   <= 1'b0;
      ackDone <= 1'b0;
    end else begin
      wbAck   <= wbCyc & wbStb & ~wbAck & ~ackDone;
      ackDone <= wbAck | (ackDone & wbStb);
    end
  end

  assign fnSel = wbAdr[clkPkg::FuncWidth-1:0];
  assign ctlWr = wbAck & wbWe & ~wbAdr[clkPkg::AdrWidth-1];
  assign ldWr  = wbAck & wbWe & wbAdr[clkPkg::AdrWidth-1];

  assign startFn    = ctlWr & (fnSel == clkPkg::FuncStart);
  assign stopFn     = ctlWr & (fnSel == clkPkg::FuncStop);
  assign stepFn     = ctlWr & (fnSel == clkPkg::FuncSingleStep);
  assign burstFn    = ctlWr & (fnSel == clkPkg::FuncBurst);
  assign clrResetFn = ctlWr & (fnSel == clkPkg::FuncClrReset);
  assign setResetFn = ctlWr & (fnSel == clkPkg::FuncSetReset);

  assign ldBurstLo  = ldWr & (fnSel == clkPkg::LdBurstLo);
  assign ldBurstHi  = ldWr & (fnSel == clkPkg::LdBurstHi);
  assign ldClkDis   = ldWr & (fnSel == clkPkg::LdClkDis);
  assign ldParCheck = ldWr & (fnSel == clkPkg::LdParCheck);
  assign ldErrStop  = ldWr & (fnSel == clkPkg::LdErrStop);

  assign ctlWord    = wbDatW;
  assign loadNibble = wbDatW[clkPkg::NibbleWidth-1:0];

  always_comb begin
    rdWord = '0;
    case (fnSel)
      clkPkg::RdBurst:    rdWord = burstCount;
      clkPkg::RdMode:     rdWord[3:0] = {runMode, burstMode, clkReset, errorStop};
      clkPkg::RdClkDis:   rdWord[2:0] = clkDisWord;
      clkPkg::RdParCheck: rdWord[2:0] = parCheckWord;
      clkPkg::RdErrStop:  rdWord[0] = errStopEn;
      clkPkg::RdErrFlags: rdWord[clkPkg::ErrWidth-1:0] = errFlags;
      clkPkg::RdParityIn: rdWord[clkPkg::ErrWidth-1:0] = parityIn;
      clkPkg::RdZero:     rdWord = '0;
      default:            rdWord = '0;
    endcase
  end

  // Data only during the ack of a read
  assign wbDatR = (wbAck & ~wbWe) ? rdWord : '0;

endmodule

`default_nettype wire

/* clkGen.sv */
// Testbench clock, period 8, and synchronous reset held for 8 cycles
`default_nettype none

module clkGen (
  output logic CLK,
  output logic rst
);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(posedge CLK);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* clkPkg.sv */
// Shared widths, diagnostic function codes, read-word selectors
// and the register-load union for the clock board
`default_nettype none

package clkPkg;

  localparam int DataWidth   = 8;
  localparam int AdrWidth    = 4;
  localparam int FuncWidth   = 3;
  localparam int NibbleWidth = 4;
  localparam int ErrWidth    = 3;  // fm, cram, dram

  // Control group 00x
  localparam logic [FuncWidth-1:0] FuncStart      = 3'd1;
  localparam logic [FuncWidth-1:0] FuncStop       = 3'd2;
  localparam logic [FuncWidth-1:0] FuncSingleStep = 3'd3;
  localparam logic [FuncWidth-1:0] FuncBurst      = 3'd5;
  localparam logic [FuncWidth-1:0] FuncClrReset   = 3'd6;
  localparam logic [FuncWidth-1:0] FuncSetReset   = 3'd7;

  // Load group 04x
  localparam logic [FuncWidth-1:0] LdBurstLo  = 3'd2;
  localparam logic [FuncWidth-1:0] LdBurstHi  = 3'd3;
  localparam logic [FuncWidth-1:0] LdClkDis   = 3'd5;
  localparam logic [FuncWidth-1:0] LdParCheck = 3'd6;
  localparam logic [FuncWidth-1:0] LdErrStop  = 3'd7;

  // Status words
  localparam logic [FuncWidth-1:0] RdBurst    = 3'd0;
  localparam logic [FuncWidth-1:0] RdMode     = 3'd1;
  localparam logic [FuncWidth-1:0] RdClkDis   = 3'd2;
  localparam logic [FuncWidth-1:0] RdParCheck = 3'd3;
  localparam logic [FuncWidth-1:0] RdErrStop  = 3'd4;
  localparam logic [FuncWidth-1:0] RdErrFlags = 3'd5;
  localparam logic [FuncWidth-1:0] RdParityIn = 3'd6;
  localparam logic [FuncWidth-1:0] RdZero     = 3'd7;

  typedef struct packed {
    logic [DataWidth-4:0] rsvd;
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } clkDisView_t;

  typedef struct packed {
    logic [DataWidth-4:0] rsvd;
    logic fmCheck;
    logic cramCheck;
    logic dramCheck;
  } parCheckView_t;

  typedef struct packed {
    logic [DataWidth-2:0] rsvd;
    logic errStopEn;
  } errStopView_t;

  // Same write word, decoded per target register
  typedef union packed {
    clkDisView_t   clkDis;
    parCheckView_t parCheck;
    errStopView_t  errStop;
  } ctlWord_u;

endpackage

`default_nettype wire

/* eboxClkGate.sv */
// Run, burst and single-step mode state, clock reset flop
// and the EBOX, CRM, EDP and CTL clock enables
`default_nettype none

module eboxClkGate (
  input  logic CLK,
  input  logic rst,
  input  logic startFn,
  input  logic stopFn,
  input  logic stepFn,
  input  logic burstFn,
  input  logic clrResetFn,
  input  logic setResetFn,
  input  logic burstZero,
  input  logic errorStop,
  input  logic crmDis,
  input  logic edpDis,
  input  logic ctlDis,
  output logic runMode,
  output logic burstMode,
  output logic clkReset,
  output logic eboxClkEn,
  output logic crmClkEn,
  output logic edpClkEn,
  output logic ctlClkEn,
  output logic burstStep
);

  logic enReg;
  logic stepPend;  // Step held off by an error stop
  logic runGo;
  logic burstGo;
  logic stepGo;

  // Requests for an enable in the next cycle
  assign runGo   = (runMode | startFn) & ~stopFn & ~errorStop;
  assign burstGo = (burstMode | burstFn) & ~burstZero & ~stopFn & ~errorStop;
  assign stepGo  = (stepPend | stepFn) & ~stopFn & ~errorStop;

  // One count per enabled burst cycle, taken as the cycle is granted
  assign burstStep = burstGo;

  always_ff @(posedge CLK) begin
    if (rst) begin
      runMode   <= 1'b0;
      burstMode <= 1'b0;
      stepPend  <= 1'b0;
      enReg     <= 1'b0;
      clkReset  <= 1'b1;
    end else begin
      runMode   <= runGo & ~stepFn;
      burstMode <= burstGo;  // Drops once the count is exhausted
      stepPend  <= (stepPend | stepFn) & errorStop & ~stopFn;
      enReg     <= runGo | burstGo | stepGo;

      // Clear-reset presets the flop, set-reset loads zero
      if (clrResetFn)
        clkReset <= 1'b1;
      else if (setResetFn)
        clkReset <= 1'b0;
    end
  end

  // A flag latched at this edge must stop the cycle already granted
  assign eboxClkEn = enReg & ~errorStop;

  assign crmClkEn = eboxClkEn & ~crmDis;
  assign edpClkEn = eboxClkEn & ~edpDis;
  assign ctlClkEn = eboxClkEn & ~ctlDis;

endmodule

`default_nettype wire

/* parityErrLatch.sv */
// Sticky FM, CRAM and DRAM parity error flags and error stop
`default_nettype none

module parityErrLatch (
  input  logic                        CLK,
  input  logic                        rst,
  input  logic                        clrResetFn,
  input  logic                        eboxClkEn,
  input  logic                        fmParityOk,
  input  logic                        cramParityOk,
  input  logic                        dramParityOk,
  input  logic                        fmCheck,
  input  logic                        cramCheck,
  input  logic                        dramCheck,
  input  logic                        errStopEn,
  output logic [clkPkg::ErrWidth-1:0] errFlags,
  output logic                        errorStop
);

  logic [clkPkg::ErrWidth-1:0] parFail;

  // Only sampled on cycles the EBOX actually clocks
  assign parFail = {fmCheck & ~fmParityOk,
                    cramCheck & ~cramParityOk,
                    dramCheck & ~dramParityOk} & {clkPkg::ErrWidth{eboxClkEn}};

  always_ff @(posedge CLK) begin
    if (rst || clrResetFn)
      errFlags <= '0;
    else
      errFlags <= errFlags | parFail;
  end

  assign errorStop = (|errFlags) & errStopEn;

endmodule

`default_nettype wire

/* sim.f */
clkPkg.sv
clkDiagPort.sv
clkCtlRegs.sv
burstCounter.sv
eboxClkGate.sv
parityErrLatch.sv
clkBoard.sv
clkBoard_checker.sv
clkGen.sv
clkBoard_tb.sv
